// File: bench/pcs_tx_model.sv
// transmit PCS reference model
// regroups SerDes words into blocks, splits off markers and descrambles the rest
`timescale 1ns/1ps

module pcs_tx_model #(
	parameter int LANE_N = 4
)(
	input  logic                         clk,
	input  logic                         reset_i,
	input  pcs_pkg::data_t [LANE_N-1:0]  words_i
);

	// expected slots, filled by the testbench at each accept
	pcs_pkg::block_t [LANE_N-1:0] exp_q[$];
	string                        name_q[$];
	bit                           tab_q[$];   // slot came from the stimulus table
	// recovered slots
	pcs_pkg::block_t [LANE_N-1:0] rec_q[$];   // descrambled payload blocks
	pcs_pkg::block_t [LANE_N-1:0] mk_q[$];    // marker slots as received
	pcs_pkg::bip_t [LANE_N-1:0]   mk_bip_q[$]; // model parity before each marker
	int                           gap_q[$];   // payload slots before each marker
	int                           head_errs = 0;

	logic [191:0]                 sbuf [LANE_N];  // received bits, oldest in 0
	int                           fill = 0;
	bit                           locked = 0;
	logic [57:0]                  ds = '1;        // descrambler history
	pcs_pkg::bip_t [LANE_N-1:0]   bip = '0;
	int                           gap = 0;
	pcs_pkg::block_t [LANE_N-1:0] slot;
	pcs_pkg::block_t [LANE_N-1:0] plain;

	// interleaved parity in send order, sync bits land on 3 and 4
	function automatic pcs_pkg::bip_t block_parity(input pcs_pkg::block_t b);
		logic [65:0]   v;
		pcs_pkg::bip_t p;
		int            pos;
		v = b;
		p = '0;
		for (int n = 0; n < 66; n++) begin
			pos = (n == 0) ? 3 : (n == 1) ? 4 : (n - 2) % 8;
			p[pos] = p[pos] ^ v[n];
		end
		return p;
	endfunction

	task automatic take_slot();
		logic in_bit;
		for (int l = 0; l < LANE_N; l++) begin
			if (slot[l].head != pcs_pkg::HEAD_DATA && slot[l].head != pcs_pkg::HEAD_CTRL)
				head_errs++;
		end
		if (slot[0].head == pcs_pkg::HEAD_CTRL &&
			slot[0].data[23:0] == pcs_pkg::AM_LANE_CODE[0]) begin
			mk_q.push_back(slot);
			mk_bip_q.push_back(bip);
			gap_q.push_back(gap);
			gap = 0;
			for (int l = 0; l < LANE_N; l++)
				bip[l] = block_parity(slot[l]);  // marker opens the next period
		end else begin
			for (int l = 0; l < LANE_N; l++) begin
				bip[l] = bip[l] ^ block_parity(slot[l]);
				plain[l].head = slot[l].head;
				for (int i = 0; i < 64; i++) begin  // x^39 + x^58 taps, serial over lanes
					in_bit = slot[l].data[i];
					plain[l].data[i] = in_bit ^ ds[38] ^ ds[57];
					ds = {ds[56:0], in_bit};
				end
			end
			rec_q.push_back(plain);
			gap++;
		end
	endtask

	// sample mid cycle, words are stable
	always @(negedge clk) begin
		if (reset_i) begin
			locked = 1'b0;
			fill   = 0;
			for (int l = 0; l < LANE_N; l++)
				sbuf[l] = '0;
		end else begin
			if (!locked && words_i[0] != '0)
				locked = 1'b1;  // first block starts with a sync header
			if (locked) begin
				for (int l = 0; l < LANE_N; l++)
					sbuf[l] = sbuf[l] | (192'(words_i[l]) << fill);
				fill += 64;
				if (fill >= 66) begin
					for (int l = 0; l < LANE_N; l++) begin
						slot[l] = sbuf[l][65:0];
						sbuf[l] = sbuf[l] >> 66;
					end
					fill -= 66;
					take_slot();
				end
			end
		end
	end

endmodule

// File: bench/pcs_tx_tb.sv
// testbench for the 40GBASE-R transmit PCS
// table of MAC words with expected blocks checked through the reference model
`timescale 1ns/1ps

module pcs_tx_tb;

	localparam int LANE_N     = 4;
	localparam int AM_PERIOD  = 40;
	localparam int TAB_N      = 120;
	localparam int WD_CYCLES  = TAB_N * 2 * (AM_PERIOD + 33) / 32 + 200;
	localparam int FIRST_STALL = 35;  // 3 cycle fill then 32 accepts

	logic                              clk = 1'b0;
	logic                              reset_i;
	logic                              valid_i;
	pcs_pkg::mac_lane_t [LANE_N-1:0]   mac_i;
	logic                              ready_o;
	logic                              marker_v_o;
	pcs_pkg::data_t [LANE_N-1:0]       serdes_data_o;

	// stimulus table
	string                             tname [TAB_N];
	pcs_pkg::mac_lane_t [LANE_N-1:0]   tmac [TAB_N];
	pcs_pkg::block_t [LANE_N-1:0]      texp [TAB_N];

	int seed = 32'h31a6_1077;
	int err_cnt = 0;
	int tab_found = 0;
	int markers_seen = 0;
	int marker_slots = 0;  // accepts lost to a marker
	int marker_rises = 0;
	int cyc = 0;
	int drv_idx = 0;
	logic mv_prev = 1'b0;
	pcs_pkg::block_t [LANE_N-1:0] idle_slot;

	pcs_tx #(.LANE_N(LANE_N), .AM_PERIOD(AM_PERIOD)) pcs_tx_i (
		.clk(clk), .reset_i(reset_i), .valid_i(valid_i), .mac_i(mac_i),
		.ready_o(ready_o), .marker_v_o(marker_v_o), .serdes_data_o(serdes_data_o)
	);

	pcs_tx_model #(.LANE_N(LANE_N)) model_i (
		.clk(clk), .reset_i(reset_i), .words_i(serdes_data_o)
	);

	always #20 clk = ~clk;

	task automatic stop_on_error();
		err_cnt++;
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		stop_on_error();
	endtask

	task automatic check_block(input string name, input pcs_pkg::block_t exp,
		input pcs_pkg::block_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_bip(input string name, input pcs_pkg::bip_t exp,
		input pcs_pkg::bip_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_on_error();
		end
	endtask

	// eight copies of a 7 bit control code after the type byte
	function automatic pcs_pkg::data_t ctrl_block(input logic [6:0] code);
		pcs_pkg::data_t d;
		d = {56'b0, pcs_pkg::BT_IDLE};
		for (int c = 0; c < 8; c++)
			d[8 + 7*c +: 7] = code;
		return d;
	endfunction

	task automatic fill_table();
		int kind;
		int nb;
		pcs_pkg::data_t d;
		for (int i = 0; i < TAB_N; i++) begin
			tname[i] = $sformatf("entry%0d", i);
			for (int l = 0; l < LANE_N; l++) begin
				kind = (i * 5 + l) % 12;  // data, idle, error, start, term 0..7
				d = {$random(seed), $random(seed)};
				tmac[i][l] = '0;
				tmac[i][l].data = d;
				texp[i][l].head = pcs_pkg::HEAD_CTRL;
				if (kind == 0) begin
					texp[i][l] = {d, pcs_pkg::HEAD_DATA};
				end else if (kind == 1) begin
					tmac[i][l].ctrl = 1'b1;
					tmac[i][l].idle = 1'b1;
					texp[i][l].data = ctrl_block(7'h00);
				end else if (kind == 2) begin
					tmac[i][l].ctrl = 1'b1;
					tmac[i][l].err  = 1'b1;
					texp[i][l].data = ctrl_block(7'h1E);
				end else if (kind == 3) begin
					tmac[i][l].ctrl  = 1'b1;
					tmac[i][l].start = 1'b1;
					texp[i][l].data  = {d[63:8], 8'h78};  // /S/ rides in the type
				end else begin
					nb = kind - 4;
					tmac[i][l].ctrl = 1'b1;
					tmac[i][l].term = 1'b1;
					tmac[i][l].keep = 8'((1 << nb) - 1);
					texp[i][l].data = {56'b0, pcs_pkg::BT_TERM[nb]};
					for (int j = 0; j < nb; j++)
						texp[i][l].data[8 + 8*j +: 8] = d[8*j +: 8];
				end
			end
		end
	endtask

	task automatic push_expected(input pcs_pkg::block_t [LANE_N-1:0] b, input string n,
		input bit tab);
		model_i.exp_q.push_back(b);
		model_i.name_q.push_back(n);
		model_i.tab_q.push_back(tab);
	endtask

	// pop recovered slots and markers and compare them
	task automatic check_results();
		pcs_pkg::block_t [LANE_N-1:0] e;
		pcs_pkg::block_t [LANE_N-1:0] g;
		pcs_pkg::bip_t [LANE_N-1:0]   bp;
		pcs_pkg::block_t              mk;
		string                        nm;
		if (model_i.head_errs != 0)
			report_failure("lost block lock, a sync header was neither 01 nor 10");
		while (model_i.rec_q.size() > 0) begin
			if (model_i.exp_q.size() == 0)
				report_failure("a block was recovered with nothing expected");
			g  = model_i.rec_q.pop_front();
			e  = model_i.exp_q.pop_front();
			nm = model_i.name_q.pop_front();
			if (model_i.tab_q.pop_front())
				tab_found++;
			for (int l = 0; l < LANE_N; l++)
				check_block($sformatf("%s_lane%0d", nm, l), e[l], g[l]);
		end
		while (model_i.mk_q.size() > 0) begin
			g  = model_i.mk_q.pop_front();
			bp = model_i.mk_bip_q.pop_front();
			check_count("marker_gap", AM_PERIOD, model_i.gap_q.pop_front());
			for (int l = 0; l < LANE_N; l++) begin
				nm = $sformatf("marker%0d_lane%0d", markers_seen, l);
				mk.head = pcs_pkg::HEAD_CTRL;
				mk.data = {~bp[l], ~pcs_pkg::AM_LANE_CODE[l], bp[l], pcs_pkg::AM_LANE_CODE[l]};
				check_bip({nm, "_bip3"}, bp[l], g[l].data[31:24]);
				check_bip({nm, "_bip7"}, ~bp[l], g[l].data[63:56]);
				check_block(nm, mk, g[l]);
			end
			markers_seen++;
		end
	endtask

	initial begin
		reset_i = 1'b1;
		valid_i = 1'b0;
		for (int l = 0; l < LANE_N; l++) begin
			mac_i[l] = '0;
			idle_slot[l] = {ctrl_block(7'h00), pcs_pkg::HEAD_CTRL};
		end
		fill_table();
		push_expected(idle_slot, "reset_idle", 1'b0);  // mac register idles out of reset
		for (int r = 0; r < 3; r++) begin
			@(posedge clk);
			check_ready("reset_ready", 1'b0, ready_o);  // no word taken in reset
		end
		reset_i <= 1'b0;
		while (tab_found < TAB_N) begin
			@(posedge clk);
			cyc++;
			// gearbox gives one stall slot in 33 and markers take the rest
			if (cyc >= FIRST_STALL && (cyc - FIRST_STALL) % 33 == 0)
				check_ready("gearbox_stall", 1'b0, ready_o);
			else if (cyc < FIRST_STALL)
				check_ready("startup_ready", 1'b1, ready_o);
			else if (!ready_o)
				marker_slots++;
			if (marker_v_o && !mv_prev)
				marker_rises++;
			mv_prev = marker_v_o;
			if (ready_o) begin
				if (valid_i) begin
					push_expected(texp[drv_idx], tname[drv_idx], 1'b1);
					drv_idx++;
				end else begin
					push_expected(idle_slot, "filler_idle", 1'b0);
				end
			end
			if (drv_idx < TAB_N) begin
				valid_i <= ($random(seed) & 7) != 0;  // occasional gap
				mac_i   <= tmac[drv_idx];
			end else begin
				valid_i <= 1'b0;
			end
			check_results();
		end
		if (markers_seen < 2)
			report_failure("fewer than two alignment markers were seen");
		if (marker_slots - markers_seen < 0 || marker_slots - markers_seen > 1)
			report_failure("ready_o low slots do not match the markers seen");
		if (marker_rises - markers_seen < 0 || marker_rises - markers_seen > 1)
			report_failure("marker_v_o pulses do not match the markers seen");
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// watchdog sized from table length and marker period
	initial begin
		repeat (WD_CYCLES + 3) @(posedge clk);
		report_failure("timeout, not all table entries came out of the SerDes lanes");
	end

endmodule

// File: hdl/am_tx.sv
// alignment marker insertion for the 40GBASE-R lanes
// counts blocks, keeps per lane BIP3 and swaps in a marker every AM_PERIOD blocks
`timescale 1ns/1ps

module am_tx #(
	parameter int LANE_N    = 4,
	parameter int AM_PERIOD = 16383
)(
	input  logic                         clk,
	input  logic                         reset_i,
	input  logic                         advance_i,  // gearbox takes a block
	input  pcs_pkg::block_t [LANE_N-1:0] blocks_i,
	output pcs_pkg::block_t [LANE_N-1:0] blocks_o,
	output logic                         marker_due_o,  // marker goes out on next advance
	output logic                         marker_v_o     // blocks_o holds markers
);

	localparam int CNT_W = $clog2(AM_PERIOD + 1);

	logic [CNT_W-1:0]             cnt_q;   // blocks passed since last marker
	pcs_pkg::bip_t [LANE_N-1:0]   bip_q;
	pcs_pkg::block_t [LANE_N-1:0] marker;
	logic                         blk_v;   // header 00 is the empty block after reset

	// parity byte of one block where payload bit d lands on BIP bit d mod 8
	// sync bits 0 and 1 fold into BIP bits 3 and 4
	function automatic pcs_pkg::bip_t bip_fold(input pcs_pkg::block_t b);
		pcs_pkg::bip_t p;
		p = '0;
		for (int i = 0; i < 8; i++) begin
			p = p ^ b.data[i*8 +: 8];
		end
		p[3] = p[3] ^ b.head[0];
		p[4] = p[4] ^ b.head[1];
		return p;
	endfunction

	always_comb begin
		for (int l = 0; l < LANE_N; l++) begin
			marker[l].head = pcs_pkg::HEAD_CTRL;
			// M0 M1 M2 BIP3 then the complements with BIP7 last
			marker[l].data = {~bip_q[l], ~pcs_pkg::AM_LANE_CODE[l],
				bip_q[l], pcs_pkg::AM_LANE_CODE[l]};
		end
	end

	assign blk_v = blocks_i[0].head != '0;  // lanes move together

	always_ff @(posedge clk) begin
		if (reset_i) begin
			cnt_q        <= '0;
			marker_due_o <= 1'b0;
			marker_v_o   <= 1'b0;
			bip_q        <= '0;
			for (int l = 0; l < LANE_N; l++) begin
				blocks_o[l].head <= '0;
			end
		end else if (advance_i) begin
			marker_v_o <= marker_due_o;
			if (marker_due_o) begin
				blocks_o     <= marker;
				marker_due_o <= 1'b0;
				// next parity period starts with the marker itself
				for (int l = 0; l < LANE_N; l++) begin
					bip_q[l] <= bip_fold(marker[l]);
				end
			end else begin
				blocks_o <= blocks_i;
				if (blk_v) begin
					for (int l = 0; l < LANE_N; l++) begin
						bip_q[l] <= bip_q[l] ^ bip_fold(blocks_i[l]);
					end
					if (cnt_q == CNT_W'(AM_PERIOD - 1)) begin
						cnt_q        <= '0;
						marker_due_o <= 1'b1;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
			end
		end
	end

	// the scrambled block under a marker slot is held upstream and not lost
	assert property (@(posedge clk) disable iff (reset_i)
		$rose(marker_v_o) |-> $stable(blocks_i));

endmodule

// File: hdl/gearbox_tx.sv
// 66 to 64 bit transmit gearbox for one lane
// buffers blocks and emits one SerDes word per cycle, header bits first
`timescale 1ns/1ps

module gearbox_tx (
	input  logic            clk,
	input  logic            reset_i,
	input  pcs_pkg::block_t block_i,
	output logic            accept_o,  // block_i taken at this edge
	output pcs_pkg::data_t  word_o
);

	logic [127:0] sh_q;      // bit buffer, oldest bit in 0
	logic [127:0] sh_n;
	logic [127:0] blk_ext;   // incoming block moved to its slot
	logic [7:0]   fill_q;    // valid bits in sh_q, 64..128 once running
	logic [5:0]   phase_q;   // accepts since the last stall, 0..32
	logic [6:0]   ins_pos;
	logic         started_q;
	logic         blk_v;

	// 32 accepts then one idle slot, 33 words of 64 carry 32 blocks of 66
	assign accept_o = ~started_q | (phase_q != 6'd32);
	assign blk_v    = block_i.head != '0;
	assign word_o   = sh_q[63:0];

	always_comb begin
		ins_pos = started_q ? 7'(fill_q - 8'd64) : 7'd0;  // room left after the shift
		blk_ext = 128'(block_i) << ins_pos;
		sh_n    = {64'b0, sh_q[127:64]};
		if (accept_o && (started_q || blk_v)) begin
			sh_n = sh_n | blk_ext;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			sh_q      <= '0;  // zero words until the first block
			fill_q    <= '0;
			phase_q   <= '0;
			started_q <= 1'b0;
		end else begin
			sh_q <= sh_n;
			if (!started_q) begin
				if (blk_v) begin
					started_q <= 1'b1;
					fill_q    <= 8'd66;
					phase_q   <= 6'd1;
				end
			end else if (accept_o) begin
				fill_q  <= fill_q + 8'd2;  // 66 in, 64 out
				phase_q <= phase_q + 1'b1;
			end else begin
				fill_q  <= fill_q - 8'd64;
				phase_q <= '0;
			end
		end
	end

	// fill tracking and the accept phase must stay in step
	assert property (@(posedge clk) disable iff (reset_i)
		started_q |-> fill_q >= 8'd64);

endmodule

// File: hdl/pcs_enc_lite.sv
// 64b/66b encoder for one lane
// maps MAC flags, data and keep onto a data or control block
`timescale 1ns/1ps

module pcs_enc_lite (
	input  pcs_pkg::mac_lane_t lane_i,
	output pcs_pkg::block_t    block_o
);

	logic [2:0]     keep_cnt;  // bytes before /T/
	pcs_pkg::data_t kept;      // data with unkept bytes cleared
	logic           no_type;   // ctrl set but no block type flag

	// eight copies of one control character, C0 in the low bits
	function automatic logic [55:0] ctrl_fill(input pcs_pkg::ctrl_code_t c);
		logic [55:0] f;
		for (int i = 0; i < 8; i++) begin
			f[i*7 +: 7] = c;
		end
		return f;
	endfunction

	assign keep_cnt = 3'($countones(lane_i.keep));
	assign no_type  = ~(lane_i.idle | lane_i.start | lane_i.term);

	always_comb begin
		for (int i = 0; i < 8; i++) begin
			kept[i*8 +: 8] = lane_i.keep[i] ? lane_i.data[i*8 +: 8] : 8'h00;
		end
	end

	always_comb begin
		// plain data by default
		block_o.head = pcs_pkg::HEAD_DATA;
		block_o.data = lane_i.data;

		if (lane_i.ctrl) begin
			block_o.head = pcs_pkg::HEAD_CTRL;
			if (lane_i.err | no_type) begin
				// error wins, an untyped control word is also sent as /E/
				block_o.data = {ctrl_fill(pcs_pkg::CC_ERROR), pcs_pkg::BT_IDLE};
			end else if (lane_i.idle) begin
				block_o.data = {ctrl_fill(pcs_pkg::CC_IDLE), pcs_pkg::BT_IDLE};
			end else if (lane_i.start) begin
				// byte 0 is /S/, carried by the type field
				block_o.data = {lane_i.data[63:8], pcs_pkg::BT_START};
			end else begin
				// terminate, data bytes follow the type, idle codes and pad are zero
				block_o.data = {kept[55:0], pcs_pkg::BT_TERM[keep_cnt]};
			end
		end
	end

	// the MAC never marks a word as two kinds of control block
	always_comb begin
		if (lane_i.ctrl) begin
			assert ($onehot0({lane_i.start, lane_i.term, lane_i.idle}))
			else $error("pcs_enc_lite: more than one of start, term, idle set");
		end
	end

endmodule

// File: hdl/pcs_pkg.sv
// 40GBASE-R transmit PCS shared definitions
// block, MAC lane and alignment marker types plus 64b/66b code points
package pcs_pkg;

	// widths with a meaning
	typedef logic [63:0] data_t;     // block payload
	typedef logic [1:0]  head_t;     // sync header
	typedef logic [7:0]  keep_t;     // byte keep, bit n covers byte n
	typedef logic [7:0]  bip_t;      // bit interleaved parity byte
	typedef logic [7:0]  btype_t;    // control block type field
	typedef logic [6:0]  ctrl_code_t; // 7 bit control character
	typedef logic [23:0] am_code_t;  // {M2, M1, M0}

	// sync header values
	localparam head_t HEAD_DATA = 2'b01;
	localparam head_t HEAD_CTRL = 2'b10;

	// one 66 bit block, header in the low bits so it is sent first
	typedef struct packed {
		data_t data;
		head_t head;
	} block_t;

	// one lane of MAC input
	typedef struct packed {
		logic  ctrl;  // word carries control, not plain data
		logic  idle;
		logic  start;
		logic  term;
		logic  err;
		data_t data;
		keep_t keep;  // valid bytes on terminate, contiguous from byte 0
	} mac_lane_t;

	// alignment marker table
	localparam int LANE_N_MAX = 4;

	// M0 in bits 7:0, M2 in bits 23:16
	localparam am_code_t [LANE_N_MAX-1:0] AM_LANE_CODE = {
		24'h3D79A2,  // lane 3
		24'h9B65C5,  // lane 2
		24'hE6C4F0,  // lane 1
		24'h477690   // lane 0
	};

	// control block types
	localparam btype_t BT_IDLE  = 8'h1E; // idle or error, eight control codes
	localparam btype_t BT_START = 8'h78; // start in byte 0

	// terminate types, index is the number of data bytes before /T/
	localparam btype_t [7:0] BT_TERM = {
		8'hFF, 8'hE1, 8'hD2, 8'hCC, 8'hB4, 8'hAA, 8'h99, 8'h87
	};

	// 7 bit control characters
	localparam ctrl_code_t CC_IDLE  = 7'h00;
	localparam ctrl_code_t CC_ERROR = 7'h1E;

endpackage

// File: hdl/pcs_tx.sv
// 40GBASE-R transmit PCS that encodes, scrambles, marks and gears down
// every stage moves on the lane 0 gearbox accept
`timescale 1ns/1ps

module pcs_tx #(
	parameter int LANE_N    = 4,
	parameter int AM_PERIOD = 16383
)(
	input  logic                           clk,
	input  logic                           reset_i,
	input  logic                           valid_i,
	input  pcs_pkg::mac_lane_t [LANE_N-1:0] mac_i,
	output logic                           ready_o,     // MAC word taken when valid_i
	output logic                           marker_v_o,  // marker slot in the pipe
	output pcs_pkg::data_t [LANE_N-1:0]    serdes_data_o
);

	// idle word filled in when the MAC has nothing
	localparam pcs_pkg::mac_lane_t IDLE_WORD = '{ctrl: 1'b1, idle: 1'b1, default: '0};

	pcs_pkg::mac_lane_t [LANE_N-1:0] mac_q;
	pcs_pkg::block_t [LANE_N-1:0]    enc_blocks;
	pcs_pkg::block_t [LANE_N-1:0]    scr_blocks;
	pcs_pkg::block_t [LANE_N-1:0]    am_blocks;
	logic [LANE_N-1:0]               gb_accept;
	logic                            advance;
	logic                            marker_due;

	assign advance = gb_accept[0];  // same on every lane with one clock and reset
	assign ready_o = advance & ~marker_due & ~reset_i;  // nothing taken in reset

	always_ff @(posedge clk) begin
		if (reset_i) begin
			mac_q <= {LANE_N{IDLE_WORD}};
		end else if (ready_o) begin
			mac_q <= valid_i ? mac_i : {LANE_N{IDLE_WORD}};
		end
	end

	for (genvar l = 0; l < LANE_N; l++) begin : gen_enc
		pcs_enc_lite pcs_enc_lite_i (
			.lane_i (mac_q[l]),
			.block_o(enc_blocks[l])
		);
	end

	// scrambler holds while the marker takes the slot
	scrambler_tx #(.LANE_N(LANE_N)) scrambler_tx_i (
		.clk      (clk),
		.reset_i  (reset_i),
		.advance_i(ready_o),
		.blocks_i (enc_blocks),
		.blocks_o (scr_blocks)
	);

	am_tx #(.LANE_N(LANE_N), .AM_PERIOD(AM_PERIOD)) am_tx_i (
		.clk         (clk),
		.reset_i     (reset_i),
		.advance_i   (advance),
		.blocks_i    (scr_blocks),
		.blocks_o    (am_blocks),
		.marker_due_o(marker_due),
		.marker_v_o  (marker_v_o)
	);

	for (genvar l = 0; l < LANE_N; l++) begin : gen_gearbox
		gearbox_tx gearbox_tx_i (
			.clk     (clk),
			.reset_i (reset_i),
			.block_i (am_blocks[l]),
			.accept_o(gb_accept[l]),
			.word_o  (serdes_data_o[l])
		);
	end

	// all gearboxes share one accept pattern
	assert property (@(posedge clk) disable iff (reset_i)
		gb_accept == {LANE_N{gb_accept[0]}});

endmodule

// File: hdl/scrambler_tx.sv
// self synchronous 64b/66b scrambler, 1 + x^39 + x^58
// one state runs serially over the payloads of all lanes, lane 0 first
`timescale 1ns/1ps

module scrambler_tx #(
	parameter int LANE_N = 4
)(
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                            advance_i,  // held during marker slots
	input  pcs_pkg::block_t [LANE_N-1:0]    blocks_i,
	output pcs_pkg::block_t [LANE_N-1:0]    blocks_o
);

	logic [57:0]                  state_q;
	logic [57:0]                  state_n;
	pcs_pkg::block_t [LANE_N-1:0] scr;
	logic                         fb;  // scrambled bit, also shifted into state

	always_comb begin
		state_n = state_q;
		fb = 1'b0;
		for (int l = 0; l < LANE_N; l++) begin
			scr[l].head = blocks_i[l].head;  // headers go out in clear
			for (int i = 0; i < 64; i++) begin
				fb = blocks_i[l].data[i] ^ state_n[38] ^ state_n[57];
				scr[l].data[i] = fb;
				state_n = {state_n[56:0], fb};  // newest bit in 0
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= '1;
			for (int l = 0; l < LANE_N; l++) begin
				blocks_o[l].head <= '0;  // no block yet
			end
		end else if (advance_i) begin
			state_q  <= state_n;
			blocks_o <= scr;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the transmit PCS testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module pcs_tx_tb \
	-o pcs_tx_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/pcs_tx_sim > sim.log 2>&1

grep -q "No errors" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }

// File: src.f
hdl/pcs_pkg.sv
hdl/pcs_enc_lite.sv
hdl/scrambler_tx.sv
hdl/am_tx.sv
hdl/gearbox_tx.sv
hdl/pcs_tx.sv
bench/pcs_tx_model.sv
bench/pcs_tx_tb.sv
